/* all.f */
+incdir+rtl
rtl/mac_types_pkg.sv
rtl/array_ctrl_pkg.sv
rtl/array_ctrl.sv
rtl/booth_r8_encoder.sv
rtl/triple_gen.sv
rtl/skew_buffer.sv
rtl/booth_pe.sv
rtl/systolic_top.sv
tests/tb_clock.sv
tests/tb_systolic.sv

/* rtl/array_ctrl.sv */
`include "mac_config.svh"

module array_ctrl (
   input  logic                 CLK,
   input  logic                 rst_n,
   input  logic                 start,
   input  array_ctrl_pkg::len_t len,
   output logic                 beat_valid,
   output logic                 beat_first,
   output logic                 busy,
   output logic                 done
);
   import array_ctrl_pkg::*;

   // last accumulator load lands this many edges after the final beat
   localparam cnt_t DRAIN = cnt_t'(`MAC_ROWS + `MAC_COLS - 1);

   len_t len_q;
   cnt_t cnt;        // edges since the start edge
   logic accept;
   logic last_edge;

   assign accept    = start & ~busy;
   assign last_edge = busy & (cnt == cnt_t'(len_q) + DRAIN);

   // beat 0 is the start cycle itself
   assign beat_first = accept;
   assign beat_valid = accept | (busy & (cnt < cnt_t'(len_q)));

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         busy  <= 1'b0;
         done  <= 1'b0;
         cnt   <= '0;
         len_q <= '0;
      end else begin
         done <= last_edge;   // one cycle only
         if (accept) begin
            busy  <= 1'b1;
            len_q <= len;
            cnt   <= cnt_t'(1);
         end else if (last_edge) begin
            busy <= 1'b0;
         end else if (busy) begin
            cnt <= cnt + 1'b1;
         end
      end
   end

endmodule

/* rtl/array_ctrl_pkg.sv */
`include "mac_config.svh"

package array_ctrl_pkg;

   // must hold len + ROWS + COLS
   localparam int CNT_BITS = $clog2((1 << `MAC_LEN_BITS) + `MAC_ROWS + `MAC_COLS);

   typedef logic [`MAC_LEN_BITS-1:0] len_t;   // 1 to 63
   typedef logic [CNT_BITS-1:0]      cnt_t;

endpackage

/* rtl/booth_pe.sv */
module booth_pe (
   input  logic                   CLK,
   input  logic                   rst_n,
   input  mac_types_pkg::a_lane_t a_in,
   input  mac_types_pkg::b_lane_t b_in,
   output mac_types_pkg::a_lane_t a_out,
   output mac_types_pkg::b_lane_t b_out,
   output mac_types_pkg::acc_t    acc
);
   import mac_types_pkg::*;

   acc_t        prod_d;
   acc_t        prod_q;     // product stage, one cycle ahead of acc
   logic        prod_valid;
   logic        prod_first;
   logic        a_valid_q;
   logic        a_first_q;
   booth_word_t a_word_q;

   // magnitude the digit names, sign applied by the caller
   function automatic acc_t pick_multiple(booth_digit_t d, b_lane_t b);
      acc_t y;
      acc_t m;
      y = acc_t'(b.y);
      unique case (1'b1)
         d.single: m = y;
         d.double: m = y << 1;
         d.triple: m = acc_t'(b.ty);
         d.quad:   m = y << 2;
         default:  m = '0;
      endcase
      return m;
   endfunction

   always_comb begin
      acc_t pp;
      prod_d = '0;
      for (int g = 0; g < BOOTH_GROUPS; g++) begin
         pp = pick_multiple(a_in.word[g], b_in);
         if (a_in.word[g].neg) begin
            pp = -pp;   // two's complement, wraps at acc width
         end
         prod_d = prod_d + (pp << (3 * g));
      end
   end

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         prod_valid <= 1'b0;
         prod_first <= 1'b0;
         a_valid_q  <= 1'b0;
         a_first_q  <= 1'b0;
         acc        <= '0;
      end else begin
         prod_valid <= a_in.valid;
         prod_first <= a_in.first;
         a_valid_q  <= a_in.valid;
         a_first_q  <= a_in.first;
         if (prod_first) begin
            acc <= prod_q;   // new job replaces the old result
         end else if (prod_valid) begin
            acc <= acc + prod_q;
         end
      end
   end

   always_ff @(posedge CLK) begin
      prod_q   <= prod_d;
      a_word_q <= a_in.word;
      b_out    <= b_in;     // on to the PE below
   end

   assign a_out = '{valid: a_valid_q, first: a_first_q, word: a_word_q};

endmodule

/* rtl/booth_r8_encoder.sv */
`include "mac_config.svh"

module booth_r8_encoder (
   input  logic                    CLK,
   input  logic                    rst_n,
   input  mac_types_pkg::operand_t a_col [`MAC_ROWS],
   input  logic                    beat_valid,
   input  logic                    beat_first,
   output mac_types_pkg::a_lane_t  lanes [`MAC_ROWS]
);
   import mac_types_pkg::*;

   localparam int PAD = 3 * BOOTH_GROUPS - `MAC_WIDTH;

   logic        valid_q;
   logic        first_q;
   booth_word_t word_q [`MAC_ROWS];

   // x[0] is the bit below the group
   function automatic booth_digit_t encode_digit(logic [3:0] x);
      booth_digit_t d;
      logic         w0;
      logic         w1;
      logic         w2;
      w0       = x[0] ^ x[1];
      w1       = x[1] ^ x[2];
      w2       = x[2] ^ x[3];
      d.single = w0 & ~w2;
      d.double = w1 & ~w0;
      d.triple = w0 & w2;
      d.quad   = w2 & ~w0 & ~w1;
      d.neg    = x[3];
      return d;
   endfunction

   function automatic booth_word_t encode_word(operand_t x);
      logic [3*BOOTH_GROUPS:0] xp;
      booth_word_t             w;
      xp = {{PAD{1'b0}}, x, 1'b0};   // zero below bit 0 and above the top
      for (int g = 0; g < BOOTH_GROUPS; g++) begin
         w[g] = encode_digit(xp[3*g +: 4]);
      end
      return w;
   endfunction

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
         first_q <= 1'b0;
      end else begin
         valid_q <= beat_valid;
         first_q <= beat_first;
      end
   end

   always_ff @(posedge CLK) begin
      for (int r = 0; r < `MAC_ROWS; r++) begin
         word_q[r] <= encode_word(a_col[r]);
      end
   end

   always_comb begin
      for (int r = 0; r < `MAC_ROWS; r++) begin
         lanes[r] = '{valid: valid_q, first: first_q, word: word_q[r]};
      end
   end

endmodule

/* rtl/mac_config.svh */
`ifndef MAC_CONFIG_SVH
`define MAC_CONFIG_SVH

// operand width, unsigned
`define MAC_WIDTH      8

// accumulator width
// sums wrap modulo 2**MAC_ACC_WIDTH
`define MAC_ACC_WIDTH  24

// array size
`define MAC_ROWS       4
`define MAC_COLS       4

`define MAC_LEN_BITS   6     // job length field, 1 to 63 beats

`endif

/* rtl/mac_types_pkg.sv */
`include "mac_config.svh"

package mac_types_pkg;

   // overlapping 4-bit groups, the top one always sees a zero sign bit
   localparam int BOOTH_GROUPS = `MAC_WIDTH / 3 + 1;

   typedef logic [`MAC_WIDTH-1:0]     operand_t;
   typedef logic [`MAC_WIDTH+1:0]     triple_t;     // room for 3*y
   typedef logic [`MAC_ACC_WIDTH-1:0] acc_t;

   // one radix-8 digit, at most one magnitude flag set
   typedef struct packed {
      logic single;
      logic double;
      logic triple;
      logic quad;
      logic neg;
   } booth_digit_t;

   typedef booth_digit_t [BOOTH_GROUPS-1:0] booth_word_t;

   // row stream, tags ride along with the encoded operand
   typedef struct packed {
      logic        valid;
      logic        first;
      booth_word_t word;
   } a_lane_t;

   typedef struct packed {
      operand_t y;
      triple_t  ty;
   } b_lane_t;

endpackage

/* rtl/skew_buffer.sv */
module skew_buffer #(
   parameter type lane_t = logic,
   parameter int  LANES  = 4
) (
   input  logic  CLK,
   input  logic  rst_n,
   input  lane_t lanes_in  [LANES],
   output lane_t lanes_out [LANES]
);
   // lane 0 has no delay
   assign lanes_out[0] = lanes_in[0];

   for (genvar n = 1; n < LANES; n++) begin : g_lane
      lane_t pipe [n];   // n stages for lane n

      always_ff @(posedge CLK) begin
         if (!rst_n) begin
            for (int s = 0; s < n; s++) begin
               pipe[s] <= '0;
            end
         end else begin
            pipe[0] <= lanes_in[n];
            for (int s = 1; s < n; s++) begin
               pipe[s] <= pipe[s-1];
            end
         end
      end

      assign lanes_out[n] = pipe[n-1];
   end

endmodule

/* rtl/systolic_top.sv */
`include "mac_config.svh"

module systolic_top (
   input  logic                    CLK,
   input  logic                    rst_n,
   input  logic                    start,
   input  array_ctrl_pkg::len_t    len,
   input  mac_types_pkg::operand_t a_col [`MAC_ROWS],
   input  mac_types_pkg::operand_t b_row [`MAC_COLS],
   output logic                    busy,
   output logic                    done,
   output mac_types_pkg::acc_t     acc [`MAC_ROWS][`MAC_COLS]
);
   import mac_types_pkg::*;

   logic    beat_valid;
   logic    beat_first;
   a_lane_t a_enc  [`MAC_ROWS];
   a_lane_t a_skew [`MAC_ROWS];
   b_lane_t b_enc  [`MAC_COLS];
   b_lane_t b_skew [`MAC_COLS];

   // neighbour links, extra column / row is the grid edge
   a_lane_t a_link [`MAC_ROWS][`MAC_COLS+1];
   b_lane_t b_link [`MAC_ROWS+1][`MAC_COLS];

   array_ctrl i_ctrl (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .start      (start),
      .len        (len),
      .beat_valid (beat_valid),
      .beat_first (beat_first),
      .busy       (busy),
      .done       (done)
   );

   booth_r8_encoder i_encoder (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .a_col      (a_col),
      .beat_valid (beat_valid),
      .beat_first (beat_first),
      .lanes      (a_enc)
   );

   triple_gen i_triple (
      .CLK   (CLK),
      .rst_n (rst_n),
      .b_row (b_row),
      .lanes (b_enc)
   );

   // row i late by i, column j late by j
   skew_buffer #(.lane_t(a_lane_t), .LANES(`MAC_ROWS)) i_a_skew (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .lanes_in  (a_enc),
      .lanes_out (a_skew)
   );

   skew_buffer #(.lane_t(b_lane_t), .LANES(`MAC_COLS)) i_b_skew (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .lanes_in  (b_enc),
      .lanes_out (b_skew)
   );

   for (genvar j = 0; j < `MAC_COLS; j++) begin : g_b_edge
      assign b_link[0][j] = b_skew[j];
   end

   for (genvar i = 0; i < `MAC_ROWS; i++) begin : g_row
      assign a_link[i][0] = a_skew[i];
      for (genvar j = 0; j < `MAC_COLS; j++) begin : g_col
         booth_pe i_pe (
            .CLK   (CLK),
            .rst_n (rst_n),
            .a_in  (a_link[i][j]),
            .b_in  (b_link[i][j]),
            .a_out (a_link[i][j+1]),
            .b_out (b_link[i+1][j]),
            .acc   (acc[i][j])
         );
      end
   end

endmodule

/* rtl/triple_gen.sv */
`include "mac_config.svh"

module triple_gen (
   input  logic                    CLK,
   input  logic                    rst_n,
   input  mac_types_pkg::operand_t b_row [`MAC_COLS],
   output mac_types_pkg::b_lane_t  lanes [`MAC_COLS]
);
   import mac_types_pkg::*;

   triple_t ty_d [`MAC_COLS];

   // 3y is the only odd multiple radix-8 needs, the rest are shifts
   always_comb begin
      for (int c = 0; c < `MAC_COLS; c++) begin
         ty_d[c] = triple_t'(b_row[c]) + (triple_t'(b_row[c]) << 1);
      end
   end

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         for (int c = 0; c < `MAC_COLS; c++) begin
            lanes[c] <= '0;
         end
      end else begin
         for (int c = 0; c < `MAC_COLS; c++) begin
            lanes[c] <= '{y: b_row[c], ty: ty_d[c]};
         end
      end
   end

endmodule

/* run.sh */
#!/bin/sh
# compile and run the systolic array testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_systolic -f all.f -o tb_systolic_sim || exit 1
out=$(./obj_dir/tb_systolic_sim) || true
echo "$out"
echo "$out" | grep -qx "TEST OK" && exit 0 || exit 1

/* tests/tb_clock.sv */
module tb_clock #(
   parameter int PERIOD_NS = 40
) (
   output logic CLK
);
   timeunit 1ns;
   timeprecision 100ps;

   // free running, starts low
   initial begin
      CLK = 1'b0;
      forever begin
         #(PERIOD_NS / 2) CLK = ~CLK;
      end
   end

endmodule

/* tests/tb_systolic.sv */
`include "mac_config.svh"

module tb_systolic;
   timeunit 1ns;
   timeprecision 100ps;

   import mac_types_pkg::*;
   import array_ctrl_pkg::*;

   localparam int ROWS     = `MAC_ROWS;
   localparam int COLS     = `MAC_COLS;
   localparam int MAX_LEN  = (1 << `MAC_LEN_BITS) - 1;
   localparam int DRIVE_NS = 2;                          // after the rising edge
   localparam int TIMEOUT  = MAX_LEN + ROWS + COLS + 20;  // cycles from start to done

   logic     CLK;
   logic     rst_n;
   logic     start;
   len_t     len;
   operand_t a_col [ROWS];
   operand_t b_row [COLS];
   logic     busy;
   logic     done;
   acc_t     acc [ROWS][COLS];

   operand_t    a_mat [ROWS][MAX_LEN];   // A(i,k)
   operand_t    b_mat [MAX_LEN][COLS];   // B(k,j)
   logic [15:0] lfsr_state = 16'd48;
   int          mismatch_errors = 0;
   int          other_errors = 0;

   tb_clock #(.PERIOD_NS(40)) i_clock (.CLK(CLK));

   systolic_top i_systolic_top (
      .CLK   (CLK),
      .rst_n (rst_n),
      .start (start),
      .len   (len),
      .a_col (a_col),
      .b_row (b_row),
      .busy  (busy),
      .done  (done),
      .acc   (acc)
   );

   task automatic step();
      @(posedge CLK);
      #DRIVE_NS;
   endtask

   // galois form, one step per bit
   function automatic logic lfsr_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) begin
         lfsr_state = lfsr_state ^ 16'hB400;
      end
      return b;
   endfunction

   function automatic operand_t rand_operand();
      operand_t v;
      for (int n = 0; n < `MAC_WIDTH; n++) begin
         v[n] = lfsr_bit();
      end
      return v;
   endfunction

   task automatic check_acc(string name, acc_t got, acc_t exp);
      if (got !== exp) begin
         mismatch_errors++;
         $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp) begin
         mismatch_errors++;
         $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   // plain matrix product, wraps at the accumulator width
   function automatic acc_t model_acc(int i, int j, int n);
      acc_t s;
      s = '0;
      for (int k = 0; k < n; k++) begin
         s = s + acc_t'(a_mat[i][k]) * acc_t'(b_mat[k][j]);
      end
      return s;
   endfunction

   task automatic check_results(int n);
      for (int i = 0; i < ROWS; i++) begin
         for (int j = 0; j < COLS; j++) begin
            check_acc($sformatf("acc[%0d][%0d]", i, j), acc[i][j], model_acc(i, j, n));
         end
      end
   endtask

   task automatic drive_beat(int k);
      for (int i = 0; i < ROWS; i++) begin
         if (k < 0) a_col[i] = 8'hA5;   // ignored while valid is low
         else a_col[i] = a_mat[i][k];
      end
      for (int j = 0; j < COLS; j++) begin
         if (k < 0) b_row[j] = 8'h5A;
         else b_row[j] = b_mat[k][j];
      end
   endtask

   task automatic fill_random(int n);
      for (int k = 0; k < n; k++) begin
         for (int i = 0; i < ROWS; i++) a_mat[i][k] = rand_operand();
         for (int j = 0; j < COLS; j++) b_mat[k][j] = rand_operand();
      end
   endtask

   task automatic finish_run();
      $display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
      if (mismatch_errors == 0 && other_errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   endtask

   // e counts edges after the start edge, done is due at edge len+ROWS+COLS-1
   task automatic run_job(int n, bit poke_busy);
      int e;
      int exp_edge;
      bit seen;
      exp_edge = n + ROWS + COLS - 1;
      seen = 1'b0;
      e = 0;
      start = 1'b1;
      len = len_t'(n);
      drive_beat(0);
      step();
      start = 1'b0;
      while (!seen && e < TIMEOUT) begin
         check_flag("done", done, e == exp_edge);
         check_flag("busy", busy, e < exp_edge);
         seen = done;
         if (!seen) begin
            start = poke_busy && e == 1;   // must be refused
            if (start) len = len_t'(1);
            drive_beat(e + 1 < n ? e + 1 : -1);
            step();
            e++;
         end
      end
      if (!seen) begin
         other_errors++;
         $display("timeout: done did not pulse within %0d cycles of start", TIMEOUT);
         finish_run();
      end else begin
         step();
         check_flag("done", done, 1'b0);   // one cycle pulse
         check_flag("busy", busy, 1'b0);
      end
   endtask

   task automatic test_booth_corners();
      operand_t corner [6] = '{8'h00, 8'h07, 8'h08, 8'h7F, 8'h80, 8'hFF};
      for (int oa = 0; oa < 6; oa += 2) begin
         for (int ob = 0; ob < 6; ob += 2) begin
            for (int i = 0; i < ROWS; i++) a_mat[i][0] = corner[(oa + i) % 6];
            for (int j = 0; j < COLS; j++) b_mat[0][j] = corner[(ob + j) % 6];
            run_job(1, 1'b0);
            check_results(1);
         end
      end
   endtask

   task automatic test_full_length();
      for (int k = 0; k < MAX_LEN; k++) begin
         for (int i = 0; i < ROWS; i++) a_mat[i][k] = 8'hFF;
         for (int j = 0; j < COLS; j++) b_mat[k][j] = 8'hFF;
      end
      run_job(MAX_LEN, 1'b0);
      for (int i = 0; i < ROWS; i++) begin
         for (int j = 0; j < COLS; j++) begin
            check_acc($sformatf("acc[%0d][%0d]", i, j), acc[i][j], acc_t'(63 * 32'hFE01));
         end
      end
   endtask

   initial begin
      rst_n = 1'b0;
      start = 1'b0;
      len   = '0;
      drive_beat(-1);
      repeat (10) step();
      rst_n = 1'b1;
      step();

      check_flag("busy", busy, 1'b0);   // reset state, all accumulators zero
      check_flag("done", done, 1'b0);
      check_results(0);

      for (int i = 0; i < ROWS; i++) a_mat[i][0] = 8'd1;
      for (int j = 0; j < COLS; j++) b_mat[0][j] = 8'd1;
      run_job(1, 1'b0);
      check_results(1);

      test_booth_corners();

      fill_random(16);
      run_job(16, 1'b0);
      check_results(16);

      // second job must replace, not add to, the first
      fill_random(5);
      run_job(5, 1'b1);
      check_results(5);
      fill_random(3);
      run_job(3, 1'b1);
      check_results(3);

      test_full_length();
      finish_run();
   end

endmodule
